//--- cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    typedef logic signed [31:0] data_t;  // pixels, partial sums, score
    typedef logic [5:0] pix_idx_t;  // position within the 8x8 image

    localparam int img_dim  = 8;
    localparam int k_dim    = 3;
    localparam int conv_dim = img_dim - k_dim + 1;  // no padding
    localparam int pool_dim = conv_dim / 2;  // 2x2 window, stride 2
    localparam int fc_len   = pool_dim * pool_dim;

    // 3x3 kernel in raster order
    localparam data_t conv_kernel [k_dim*k_dim] = '{
         1,  0, -1,
         2,  1, -2,
         0, -1,  1
    };

    localparam data_t fc_weights [fc_len] = '{
         3, -1,  2,
        -2,  4,  1,
        -3,  2,  1
    };

    typedef struct packed {
        data_t [0:conv_dim*conv_dim-1] px;  // raster order
    } conv_map_t;

    typedef struct packed {
        data_t [0:fc_len-1] px;  // raster order
    } pool_map_t;

    typedef enum logic [2:0] {
        idle,
        load,
        conv_run,
        pool_run,
        fc_run,
        hold
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- conv_layer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_layer import cnn_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      px_we,
    input  data_t     px_data,
    input  logic      start,
    output logic      done,
    output conv_map_t conv_map
);

    data_t      img_buf [img_dim*img_dim];
    pix_idx_t   wr_ptr;  // wraps after a full image
    logic       busy;
    logic [2:0] out_row;
    logic [2:0] out_col;
    logic [1:0] k_row;
    logic [1:0] k_col;
    logic [2:0] img_row;
    logic [2:0] img_col;
    pix_idx_t   rd_addr;
    logic [3:0] tap_idx;
    logic [5:0] out_idx;
    logic       first_tap;
    logic       last_tap;
    data_t      acc;
    data_t      product;

    assign img_row = out_row + 3'(k_row);
    assign img_col = out_col + 3'(k_col);
    assign rd_addr = {img_row, img_col};  // row * 8 + col
    assign tap_idx = 4'(k_row * k_dim + k_col);
    assign out_idx = 6'(out_row * conv_dim + out_col);

    assign first_tap = (k_row == '0) && (k_col == '0);
    assign last_tap  = (k_row == 2'(k_dim - 1)) && (k_col == 2'(k_dim - 1));

    assign product = img_buf[rd_addr] * conv_kernel[tap_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
            out_row <= '0;
            out_col <= '0;
            k_row   <= '0;
            k_col   <= '0;
        end else begin
            done <= 1'b0;
            if (px_we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (start) begin
                busy    <= 1'b1;
                out_row <= '0;
                out_col <= '0;
                k_row   <= '0;
                k_col   <= '0;
            end else if (busy) begin
                if (k_col == 2'(k_dim - 1)) begin
                    k_col <= '0;
                    if (k_row == 2'(k_dim - 1)) begin
                        k_row <= '0;
                        if (out_col == 3'(conv_dim - 1)) begin
                            out_col <= '0;
                            if (out_row == 3'(conv_dim - 1)) begin
                                out_row <= '0;
                                busy    <= 1'b0;
                                done    <= 1'b1;  // last output written this edge
                            end else begin
                                out_row <= out_row + 1'b1;
                            end
                        end else begin
                            out_col <= out_col + 1'b1;
                        end
                    end else begin
                        k_row <= k_row + 1'b1;
                    end
                end else begin
                    k_col <= k_col + 1'b1;
                end
            end
        end
    end

    // image buffer and mac datapath
    always_ff @(posedge clk) begin
        if (px_we) begin
            img_buf[wr_ptr] <= px_data;
        end
        if (busy) begin
            acc <= first_tap ? product : acc + product;
            if (last_tap) begin
                conv_map.px[out_idx] <= acc + product;
            end
        end
    end

    // controller must wait for done before restarting
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !start)
        else $error("conv_layer: start while running");

endmodule

`default_nettype wire

//--- pool_layer.sv
`timescale 1ns/1ps
`default_nettype none

module pool_layer import cnn_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  conv_map_t conv_map,
    output logic      done,
    output pool_map_t pool_map
);

    logic       busy;
    logic [1:0] win_row;
    logic [1:0] win_col;
    logic [1:0] elem;  // position inside the 2x2 window
    logic [2:0] src_row;
    logic [2:0] src_col;
    logic [5:0] src_idx;
    logic [3:0] dst_idx;
    data_t      cand;
    data_t      max_val;

    assign src_row = {win_row, elem[1]};  // 2 * win_row + dr
    assign src_col = {win_col, elem[0]};
    assign src_idx = 6'(src_row * conv_dim + src_col);
    assign dst_idx = 4'(win_row * pool_dim + win_col);
    assign cand    = conv_map.px[src_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            win_row <= '0;
            win_col <= '0;
            elem    <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                win_row <= '0;
                win_col <= '0;
                elem    <= '0;
            end else if (busy) begin
                elem <= elem + 1'b1;  // wraps after four
                if (elem == 2'd3) begin
                    if (win_col == 2'(pool_dim - 1)) begin
                        win_col <= '0;
                        if (win_row == 2'(pool_dim - 1)) begin
                            win_row <= '0;
                            busy    <= 1'b0;
                            done    <= 1'b1;
                        end else begin
                            win_row <= win_row + 1'b1;
                        end
                    end else begin
                        win_col <= win_col + 1'b1;
                    end
                end
            end
        end
    end

    // running signed max, written out on the fourth element
    always_ff @(posedge clk) begin
        if (busy) begin
            if (elem == 2'd0) begin
                max_val <= cand;
            end else if (cand > max_val) begin
                max_val <= cand;
            end
            if (elem == 2'd3) begin
                pool_map.px[dst_idx] <= (cand > max_val) ? cand : max_val;
            end
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !start)
        else $error("pool_layer: start while busy");

endmodule

`default_nettype wire

//--- fc_layer.sv
`timescale 1ns/1ps
`default_nettype none

module fc_layer import cnn_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  pool_map_t pool_map,
    output logic      done,
    output data_t     score
);

    logic       busy;
    logic [3:0] term;
    logic       last_term;
    data_t      acc;
    data_t      product;

    assign last_term = (term == 4'(fc_len - 1));
    assign product   = pool_map.px[term] * fc_weights[term];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            term <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                term <= '0;
            end else if (busy) begin
                term <= term + 1'b1;
                if (last_term) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // one product per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (busy) begin
            acc <= acc + product;
            if (last_term) begin
                score <= acc + product;  // held until the next image
            end
        end
    end

    // done comes exactly fc_len + 1 cycles after its start
    a_done_after_start: assert property (
        @(posedge clk) disable iff (rst) $rose(done) |-> $past(start, fc_len + 1)
    ) else $error("fc_layer: done without matching start");

endmodule

`default_nettype wire

//--- cnn_top.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_top import cnn_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  pix_valid,
    input  data_t pix_data,
    output logic  pix_ready,
    output logic  res_valid,
    output data_t res_data,
    input  logic  res_ready
);

    ctrl_state_t state;
    pix_idx_t    pix_cnt;
    logic        px_we;
    logic        conv_start;
    logic        pool_start;
    logic        fc_start;
    logic        conv_done;
    logic        pool_done;
    logic        fc_done;
    conv_map_t   conv_map;
    pool_map_t   pool_map;
    data_t       fc_score;

    assign pix_ready = (state == idle) || (state == load);
    assign px_we     = pix_valid && pix_ready;  // accepted pixel
    assign res_valid = (state == hold);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= idle;
            pix_cnt    <= '0;
            conv_start <= 1'b0;
            pool_start <= 1'b0;
            fc_start   <= 1'b0;
        end else begin
            conv_start <= 1'b0;  // starts are single-cycle pulses
            pool_start <= 1'b0;
            fc_start   <= 1'b0;
            case (state)
                idle, load: begin
                    if (px_we) begin
                        pix_cnt <= pix_cnt + 1'b1;  // wraps back to zero
                        if (pix_cnt == pix_idx_t'(img_dim * img_dim - 1)) begin
                            conv_start <= 1'b1;
                            state      <= conv_run;
                        end else begin
                            state <= load;
                        end
                    end
                end
                conv_run: begin
                    if (conv_done) begin
                        pool_start <= 1'b1;
                        state      <= pool_run;
                    end
                end
                pool_run: begin
                    if (pool_done) begin
                        fc_start <= 1'b1;
                        state    <= fc_run;
                    end
                end
                fc_run: begin
                    if (fc_done) begin
                        state <= hold;
                    end
                end
                hold: begin
                    if (res_ready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // result register
    always_ff @(posedge clk) begin
        if (state == fc_run && fc_done) begin
            res_data <= fc_score;
        end
    end

    conv_layer u_conv (
        .clk      (clk),
        .rst      (rst),
        .px_we    (px_we),
        .px_data  (pix_data),
        .start    (conv_start),
        .done     (conv_done),
        .conv_map (conv_map)
    );

    pool_layer u_pool (
        .clk      (clk),
        .rst      (rst),
        .start    (pool_start),
        .conv_map (conv_map),
        .done     (pool_done),
        .pool_map (pool_map)
    );

    fc_layer u_fc (
        .clk      (clk),
        .rst      (rst),
        .start    (fc_start),
        .pool_map (pool_map),
        .done     (fc_done),
        .score    (fc_score)
    );

    // result held under back-pressure
    a_res_stable: assert property (
        @(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_data)
    ) else $error("cnn_top: result changed while stalled");

endmodule

`default_nettype wire

//--- tb_cnn_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_top;

    localparam int n_px        = 64;
    localparam int px_timeout  = 50;  // cycles per pixel handshake
    localparam int res_timeout = 2000;
    localparam int exp_results = 8;

    localparam int k_w [0:8] = '{1, 0, -1, 2, 1, -2, 0, -1, 1};  // conv kernel, raster
    localparam int f_w [0:8] = '{3, -1, 2, -2, 4, 1, -3, 2, 1};

    logic               clk;
    logic               rst;
    logic               pix_valid;
    logic signed [31:0] pix_data;
    logic               pix_ready;
    logic               res_valid;
    logic signed [31:0] res_data;
    logic               res_ready = 1'b0;

    integer seed;
    int     errors = 0;
    int     timeouts;
    bit     timed_out;
    bit     stall;  // forces res_ready low
    int     img_px [0:n_px-1];
    int     exp_score;
    int     acc_cnt;  // pixels taken in the current image
    int     pending;  // full images without a result yet
    int     results = 0;

    cnn_top UUT (
        .clk       (clk),
        .rst       (rst),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_ready (pix_ready),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_ready (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        res_ready <= !stall && (($random(seed) & 3) == 0);
    end

    always @(posedge clk) begin
        if (rst) begin
            acc_cnt <= 0;
            pending <= 0;
        end else begin
            if (pix_valid && pix_ready) begin
                acc_cnt <= (acc_cnt + 1) % n_px;
            end
            if (pix_valid && pix_ready && acc_cnt == n_px - 1) begin
                pending <= pending + 1;
            end else if (res_valid && res_ready) begin
                pending <= pending - 1;
            end
            if (res_valid && res_ready) begin
                results <= results + 1;
            end
        end
    end

    a_score: assert property (@(posedge clk) disable iff (rst)
        res_valid && res_ready |-> res_data == exp_score)
        else begin
            errors++;
            $display("[FAIL] %0t res_data expected %0d actual %0d", $time,
                     $sampled(exp_score), $sampled(res_data));
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_data))
        else begin
            errors++;
            $display("result changed or vanished while res_ready was low at %0t", $time);
        end

    a_closed: assert property (@(posedge clk) disable iff (rst) pending != 0 |-> !pix_ready)
        else begin
            errors++;
            $display("pix_ready was high while a result was pending at %0t", $time);
        end

    a_reopen: assert property (@(posedge clk) disable iff (rst)
        res_valid && res_ready |=> pix_ready)
        else begin
            errors++;
            $display("pix_ready did not rise after the result transfer at %0t", $time);
        end

    a_one_result: assert property (@(posedge clk) disable iff (rst)
        res_valid && res_ready |-> pending == 1)
        else begin
            errors++;
            $display("a result came out with no image waiting for it at %0t", $time);
        end

    a_reset: assert property (@(posedge clk) rst |=> !res_valid && pix_ready)
        else begin
            errors++;
            $display("reset did not clear res_valid and raise pix_ready at %0t", $time);
        end

    function automatic int model_score();
        int conv_v [0:35];
        int pool_v [0:8];
        int sum;
        int cand;
        for (int r = 0; r < 6; r++) begin
            for (int c = 0; c < 6; c++) begin
                sum = 0;
                for (int i = 0; i < 9; i++) begin
                    sum += img_px[(r + i / 3) * 8 + c + i % 3] * k_w[i];
                end
                conv_v[r * 6 + c] = sum;
            end
        end
        for (int w = 0; w < 9; w++) begin
            sum = conv_v[(w / 3) * 12 + (w % 3) * 2];  // top left of the window
            for (int e = 1; e < 4; e++) begin
                cand = conv_v[(w / 3) * 12 + (w % 3) * 2 + (e / 2) * 6 + e % 2];
                if (cand > sum) sum = cand;
            end
            pool_v[w] = sum;
        end
        sum = 0;
        for (int n = 0; n < 9; n++) begin
            sum += pool_v[n] * f_w[n];
        end
        return sum;
    endfunction

    task automatic fill_image(input bit negative);
        int r;
        for (int i = 0; i < n_px; i++) begin
            r = $random(seed);
            if (negative) img_px[i] = {{29{1'b1}}, r[2:0]};  // -8 .. -1
            else img_px[i] = {{28{r[3]}}, r[3:0]};  // -8 .. 7
        end
        exp_score <= model_score();
    endtask

    task automatic send_image();
        int wait_cnt;
        int gap;
        for (int i = 0; i < n_px && !timed_out; i++) begin
            gap = $random(seed) & 3;
            pix_valid <= 1'b0;
            repeat (gap) @(posedge clk);
            pix_valid <= 1'b1;
            pix_data  <= img_px[i];
            wait_cnt = 0;
            do begin
                @(posedge clk);
                wait_cnt++;
            end while (!pix_ready && wait_cnt < px_timeout);
            if (!pix_ready) begin
                timeouts++;
                timed_out = 1'b1;
                $display("pixel %0d was not accepted within %0d cycles", i, px_timeout);
            end
        end
        pix_valid <= 1'b1;  // offered while busy and never taken
        pix_data  <= 32'sh7fff_0001;
    endtask

    task automatic wait_result(input bit transfer);
        int wait_cnt;
        wait_cnt = 0;
        if (!timed_out) begin
            do begin
                @(posedge clk);
                wait_cnt++;
            end while (!(res_valid && (res_ready || !transfer)) && wait_cnt < res_timeout);
            if (transfer) pix_valid <= 1'b0;
            if (!(res_valid && (res_ready || !transfer))) begin
                timeouts++;
                timed_out = 1'b1;
                $display("no result within %0d cycles", res_timeout);
            end
        end
    endtask

    initial begin
        seed      = 46274;
        rst       = 1'b1;
        pix_valid = 1'b0;
        pix_data  = '0;
        stall     = 1'b0;
        timeouts  = 0;
        timed_out = 1'b0;
        exp_score = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < 5; n++) begin  // back to back random images
            fill_image(1'b0);
            send_image();
            wait_result(1'b1);
        end
        fill_image(1'b1);  // all negative pixels
        send_image();
        wait_result(1'b1);
        stall <= 1'b1;  // long back-pressure stretch
        fill_image(1'b0);
        send_image();
        wait_result(1'b0);
        repeat (5 + ($random(seed) & 15)) @(posedge clk);
        stall <= 1'b0;
        wait_result(1'b1);
        fill_image(1'b0);  // reset while the conv layer runs
        send_image();
        repeat (60) @(posedge clk);
        rst       <= 1'b1;
        pix_valid <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        fill_image(1'b0);
        send_image();
        wait_result(1'b1);
        repeat (5) @(posedge clk);
        if (results != exp_results) begin
            errors++;
            $display("expected %0d results but saw %0d", exp_results, results);
        end
        $display("errors: %0d  timeouts: %0d  results: %0d", errors, timeouts, results);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
cnn_pkg.sv
conv_layer.sv
pool_layer.sv
fc_layer.sv
cnn_top.sv
tb_cnn_top.sv

//--- run.sh
#!/bin/sh
# build and run the cnn_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cnn_top \
    -f all.f --Mdir obj_dir -o sim_cnn > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_cnn > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0
